// File: verilog.f
+incdir+verilog
+incdir+bench
verilog/fpuPkg.sv
verilog/fpuDecode.sv
verilog/fpuRegFile.sv
verilog/fpuForward.sv
verilog/fpuCompare.sv
verilog/fpuClassify.sv
verilog/fpuExecute.sv
verilog/fpu.sv
bench/fpuTb.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fpuPkg.sv
      - verilog/fpuDecode.sv
      - verilog/fpuRegFile.sv
      - verilog/fpuForward.sv
      - verilog/fpuCompare.sv
      - verilog/fpuClassify.sv
      - verilog/fpuExecute.sv
      - verilog/fpu.sv
  - target: test
    include_dirs:
      - verilog
      - bench
    files:
      - bench/fpuTb.sv

// File: bench/fpuTbTable.svh
`ifndef FPU_TB_TABLE_SVH
`define FPU_TB_TABLE_SVH

// each call adds one row of instruction, operand or expected result, and flags
// stallLast and flushLast modify the row just added
task automatic buildTable();
  // moves through M forwarding, write-through and the regfile
  putMoveIn(1, 64'h3FF0000000000000);
  putMoveIn(2, 64'hC000000000000000);
  putMoveOut(5, 2);
  putMoveOut(6, 1);
  putRandomMoveIn(3);
  putRandomMoveIn(10);
  putRandomMoveIn(11);
  putMoveOut(7, 3);
  putMoveOut(8, 3);
  // M wins over W when both write f11
  putRandomMoveIn(11);
  putRandomMoveIn(11);
  putMoveOut(9, 11);
  // f11 now only in W
  putMoveOut(9, 11);
  // sign injection on f1 = 1.0 and f2 = -2.0
  putFpOp(rType(7'h11, 2, 1, 0, 4), 64'hBFF0000000000000);
  putFpOp(rType(7'h11, 2, 2, 1, 5), 64'h4000000000000000);
  // f4 comes from W here
  putFpOp(rType(7'h11, 2, 4, 2, 6), 64'h3FF0000000000000);
  putMoveOut(9, 5);
  putFpOp(rType(7'h11, 2, 1, 2, 7), 64'hBFF0000000000000);
  // load -0, qnan, snan and +0
  putMoveIn(12, 64'h8000000000000000);
  putMoveIn(13, 64'h7FF8000000000000);
  putMoveIn(14, 64'h7FF0000000000001);
  putMoveIn(15, 64'h0000000000000000);
  // compare funct3 is 0 for fle, 1 for flt and 2 for feq
  putIntOp(rType(7'h51, 1, 2, 1, 10), 64'h1, NoFlags);
  putIntOp(rType(7'h51, 2, 1, 1, 10), 64'h0, NoFlags);
  putIntOp(rType(7'h51, 1, 1, 0, 10), 64'h1, NoFlags);
  putIntOp(rType(7'h51, 2, 1, 2, 10), 64'h0, NoFlags);
  putIntOp(rType(7'h51, 15, 12, 2, 10), 64'h1, NoFlags);
  putIntOp(rType(7'h51, 15, 12, 1, 10), 64'h0, NoFlags);
  putIntOp(rType(7'h51, 12, 15, 0, 10), 64'h1, NoFlags);
  putIntOp(rType(7'h51, 1, 13, 2, 10), 64'h0, NoFlags);
  putIntOp(rType(7'h51, 1, 14, 2, 10), 64'h0, Invalid);
  putIntOp(rType(7'h51, 1, 13, 1, 10), 64'h0, Invalid);
  putIntOp(rType(7'h51, 14, 1, 0, 10), 64'h0, Invalid);
  // load -inf, -subnormal, +subnormal and +inf
  putMoveIn(16, 64'hFFF0000000000000);
  putMoveIn(17, 64'h8000000000000001);
  putMoveIn(18, 64'h0000000000000001);
  putMoveIn(19, 64'h7FF0000000000000);
  // fclass with one row per class
  putIntOp(rType(7'h71, 0, 16, 1, 11), 64'h001, NoFlags);
  putIntOp(rType(7'h71, 0, 2, 1, 11), 64'h002, NoFlags);
  putIntOp(rType(7'h71, 0, 17, 1, 11), 64'h004, NoFlags);
  putIntOp(rType(7'h71, 0, 12, 1, 11), 64'h008, NoFlags);
  putIntOp(rType(7'h71, 0, 15, 1, 11), 64'h010, NoFlags);
  putIntOp(rType(7'h71, 0, 18, 1, 11), 64'h020, NoFlags);
  putIntOp(rType(7'h71, 0, 1, 1, 11), 64'h040, NoFlags);
  putIntOp(rType(7'h71, 0, 19, 1, 11), 64'h080, NoFlags);
  putIntOp(rType(7'h71, 0, 14, 1, 11), 64'h100, NoFlags);
  putIntOp(rType(7'h71, 0, 13, 1, 11), 64'h200, NoFlags);
  // int writes to x11 in M and W must not reach f11
  putMoveOut(9, 11);
  // single precision fsgnj.s, then fadd.d and fmv.w.x
  putIllegal(rType(7'h10, 2, 1, 0, 3));
  putIllegal(rType(7'h01, 2, 1, 0, 3));
  putIllegal(rType(7'h78, 0, 0, 0, 5));
  // flushed load leaves f20 at zero
  putMoveIn(20, 64'h123456789ABCDEF0);
  flushLast();
  putMoveOut(12, 20);
  // stalls with valid writes sitting in W
  putRandomMoveIn(21);
  putMoveOut(13, 21);
  putFpOp(rType(7'h11, 1, 1, 1, 22), 64'hBFF0000000000000);
  stallLast(5);
  putMoveOut(14, 22);
  stallLast(2);
  putIntOp(rType(7'h51, 1, 2, 1, 15), 64'h1, NoFlags);
  flushLast();
endtask

`endif

// File: bench/fpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuTb import fpuPkg::*; ();

  localparam logic [1:0] KindNone = 2'd0;
  localparam logic [1:0] KindInt  = 2'd1;
  localparam logic [1:0] KindFp   = 2'd2;
  localparam logic [4:0] NoFlags  = 5'b00000;
  localparam logic [4:0] Invalid  = 5'b10000;
  localparam int DrainTimeout     = 20;

  // kind none marks an illegal row
  typedef struct packed {
    logic [31:0] instr;
    logic [63:0] srcA;
    logic [3:0]  stallCycles;
    logic        flush;
    logic [1:0]  kind;
    logic        fromModel;
    logic [63:0] expResult;
    logic [4:0]  expFlags;
  } stimRow_t;

  logic                 clk;
  logic                 rstN;
  logic [31:0]          instr;
  logic                 instrValid;
  logic [`FPU_XLEN-1:0] srcA;
  logic                 stall;
  logic                 flush;
  logic                 illegalInstr;
  logic                 writeIntW;
  logic                 writeFpW;
  logic [4:0]           rdW;
  logic [`FPU_FLEN-1:0] resultW;
  fpuFlags_t            flagsW;

  stimRow_t    rows[$];
  stimRow_t    pending[$];
  // moving edge at which each pending row must sit in W
  int          dueEdge[$];
  int          edgeCount;
  // reference copy of the fp registers
  logic [63:0] model [32];
  logic [11:0] heldCtl;
  logic [63:0] heldResult;
  int          errCount;
  int          timeoutCount;
  integer      seed;

  fpu uut (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .instrValid  (instrValid),
    .srcA        (srcA),
    .stall       (stall),
    .flush       (flush),
    .illegalInstr(illegalInstr),
    .writeIntW   (writeIntW),
    .writeFpW    (writeFpW),
    .rdW         (rdW),
    .resultW     (resultW),
    .flagsW      (flagsW)
  );

  initial begin
    clk = 1'b0;
  end
  always #4 clk = ~clk;

  task automatic compareValue(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  // OP-FP r-type encoding
  function automatic logic [31:0] rType(
    input logic [6:0] funct7,
    input int         rs2,
    input int         rs1,
    input int         funct3,
    input int         rd
  );
    return {funct7, rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b1010011};
  endfunction

  // ****************************************
  // table building
  // ****************************************

  task automatic putRow(
    input logic [31:0] ins,
    input logic [63:0] src,
    input logic [1:0]  kind,
    input logic        fromModel,
    input logic [63:0] result,
    input logic [4:0]  flags
  );
    stimRow_t row;
    row           = '0;
    row.instr     = ins;
    row.srcA      = src;
    row.kind      = kind;
    row.fromModel = fromModel;
    row.expResult = result;
    row.expFlags  = flags;
    rows.push_back(row);
  endtask

  // fmv.d.x returns the operand itself
  task automatic putMoveIn(input int rd, input logic [63:0] value);
    putRow(rType(7'h79, 0, 0, 0, rd), value, KindFp, 1'b0, value, NoFlags);
  endtask

  task automatic putRandomMoveIn(input int rd);
    logic [63:0] value;
    value = {$random(seed), $random(seed)};
    putMoveIn(rd, value);
  endtask

  // fmv.x.d expects the model value at W time
  task automatic putMoveOut(input int rd, input int rs1);
    putRow(rType(7'h71, 0, rs1, 0, rd), '0, KindInt, 1'b1, '0, NoFlags);
  endtask

  task automatic putFpOp(input logic [31:0] ins, input logic [63:0] result);
    putRow(ins, '0, KindFp, 1'b0, result, NoFlags);
  endtask

  task automatic putIntOp(input logic [31:0] ins, input logic [63:0] result,
                          input logic [4:0] flags);
    putRow(ins, '0, KindInt, 1'b0, result, flags);
  endtask

  task automatic putIllegal(input logic [31:0] ins);
    putRow(ins, '0, KindNone, 1'b0, '0, NoFlags);
  endtask

  task automatic stallLast(input int cycles);
    stimRow_t row;
    row             = rows.pop_back();
    row.stallCycles = cycles[3:0];
    rows.push_back(row);
  endtask

  task automatic flushLast();
    stimRow_t row;
    row       = rows.pop_back();
    row.flush = 1'b1;
    rows.push_back(row);
  endtask

  `include "fpuTbTable.svh"

  // ****************************************
  // W stage monitor
  // ****************************************

  // runs at each falling edge before new inputs
  task automatic observeW();
    stimRow_t    exp;
    logic [63:0] want;
    logic [4:0]  rd;
    int          due;
    if (!stall) begin
      edgeCount++;
    end
    if (stall) begin
      // W must hold across a stalled edge
      compareValue({writeIntW, writeFpW, rdW, flagsW}, heldCtl, "W control during stall");
      compareValue(resultW, heldResult, "W result during stall");
    end else if (writeIntW || writeFpW) begin
      if (pending.size() == 0) begin
        compareValue({writeIntW, writeFpW}, 2'b00, "write with no outstanding instruction");
      end else begin
        exp  = pending.pop_front();
        due  = dueEdge.pop_front();
        rd   = exp.instr[11:7];
        want = exp.fromModel ? model[exp.instr[19:15]] : exp.expResult;
        compareValue(edgeCount, due, "W latency");
        compareValue({writeIntW, writeFpW}, {exp.kind == KindInt, exp.kind == KindFp},
                     "W write kind");
        compareValue(rdW, rd, "W destination");
        compareValue(resultW, want, "W result");
        compareValue(flagsW, exp.expFlags, "W flags");
        if (exp.kind == KindFp) begin
          model[rd] = want;
        end
      end
    end else begin
      compareValue(flagsW, NoFlags, "flags on a bubble");
    end
    heldCtl    = {writeIntW, writeFpW, rdW, flagsW};
    heldResult = resultW;
  endtask

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    stimRow_t row;
    logic     flushNext;
    int       cycles;
    errCount     = 0;
    timeoutCount = 0;
    edgeCount    = 0;
    seed         = 32'h4b0;
    flushNext    = 1'b0;
    heldCtl      = '0;
    heldResult   = '0;
    rstN         = 1'b0;
    instr        = '0;
    instrValid   = 1'b0;
    srcA         = '0;
    stall        = 1'b0;
    flush        = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    buildTable();
    repeat (8) @(negedge clk);
    rstN = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      row        = rows[i];
      instr      = row.instr;
      instrValid = 1'b1;
      srcA       = row.srcA;
      // flush hits the previous row now in E
      flush      = flushNext;
      stall      = (row.stallCycles != 0);
      #1;
      compareValue(illegalInstr, row.kind == KindNone, "illegalInstr");
      // core holds the instruction while stalled
      for (int s = row.stallCycles; s > 0; s--) begin
        @(negedge clk);
        observeW();
        stall = (s > 1);
      end
      if (row.kind != KindNone && !row.flush) begin
        pending.push_back(row);
        // E, M and W follow on the next three moving edges
        dueEdge.push_back(edgeCount + 3);
      end
      flushNext = row.flush;
      @(negedge clk);
      observeW();
    end

    // drain the pipe
    instrValid = 1'b0;
    // a legal fmv.d.x with instrValid low must stay a bubble
    instr      = rType(7'h79, 0, 0, 0, 23);
    srcA       = '0;
    flush      = flushNext;
    cycles     = 0;
    #1;
    compareValue(illegalInstr, 1'b0, "illegalInstr with instrValid low");
    while (pending.size() != 0 && cycles < DrainTimeout) begin
      @(negedge clk);
      observeW();
      flush = 1'b0;
      cycles++;
    end
    if (pending.size() != 0) begin
      $display("timeout: %0d instructions never reached writeback", pending.size());
      timeoutCount++;
    end
    // late spurious writes
    flush = 1'b0;
    repeat (3) begin
      @(negedge clk);
      observeW();
    end

    $display("summary: %0d errors, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu import fpuPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [31:0]          instr,
  input  logic                 instrValid,
  input  logic [`FPU_XLEN-1:0] srcA,
  input  logic                 stall,
  input  logic                 flush,
  output logic                 illegalInstr,
  output logic                 writeIntW,
  output logic                 writeFpW,
  output logic [4:0]           rdW,
  output logic [`FPU_FLEN-1:0] resultW,
  output fpuFlags_t            flagsW
);

  // decode stage
  fpuCtrl_t             ctrlD;
  logic [`FPU_FLEN-1:0] rdata1D;
  logic [`FPU_FLEN-1:0] rdata2D;

  // execute stage
  fpuCtrl_t             ctrlE;
  logic [`FPU_FLEN-1:0] rdata1E;
  logic [`FPU_FLEN-1:0] rdata2E;
  logic [`FPU_XLEN-1:0] srcAE;
  logic [`FPU_FLEN-1:0] opA;
  logic [`FPU_FLEN-1:0] opB;
  fpuExStage_t          stageE;

  // memory and writeback
  fpuExStage_t          stageM;
  fpuExStage_t          stageW;
  logic                 regWe;

  // ****************************************
  // D stage
  // ****************************************

  fpuDecode decode (
    .instr       (instr),
    .instrValid  (instrValid),
    .ctrl        (ctrlD),
    .illegalInstr(illegalInstr)
  );

  // write held off while stalled, so it lands once
  assign regWe = stageW.ctrl.valid & stageW.ctrl.writeFp & ~stall;

  fpuRegFile regFile (
    .clk   (clk),
    .rstN  (rstN),
    .rs1   (ctrlD.rs1),
    .rs2   (ctrlD.rs2),
    .rdata1(rdata1D),
    .rdata2(rdata2D),
    .we    (regWe),
    .waddr (stageW.ctrl.rd),
    .wdata (stageW.result)
  );

  // D/E control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (!stall) begin
      ctrlE <= ctrlD;
    end
  end

  // D/E operands, srcA rides with its instruction
  always_ff @(posedge clk) begin
    if (!stall) begin
      rdata1E <= rdata1D;
      rdata2E <= rdata2D;
      srcAE   <= srcA;
    end
  end

  // ****************************************
  // E stage
  // ****************************************

  fpuForward forward (
    .ctrlE  (ctrlE),
    .rdata1E(rdata1E),
    .rdata2E(rdata2E),
    .stageM (stageM),
    .stageW (stageW),
    .opA    (opA),
    .opB    (opB)
  );

  fpuExecute execute (
    .ctrlE (ctrlE),
    .opA   (opA),
    .opB   (opB),
    .srcAE (srcAE),
    .stageE(stageE)
  );

  // E/M, flush turns E into a bubble
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stageM.ctrl <= '0;
    end else if (!stall) begin
      stageM <= stageE;
      if (flush) begin
        stageM.ctrl.valid <= 1'b0;
      end
    end
  end

  // ****************************************
  // M and W stages
  // ****************************************

  // nothing to do in M, payload just moves on
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stageW.ctrl <= '0;
    end else if (!stall) begin
      stageW <= stageM;
    end
  end

  // bubbles report no write and no flags
  assign writeIntW = stageW.ctrl.valid & stageW.ctrl.writeInt;
  assign writeFpW  = stageW.ctrl.valid & stageW.ctrl.writeFp;
  assign rdW       = stageW.ctrl.rd;
  assign resultW   = stageW.result;
  assign flagsW    = stageW.ctrl.valid ? stageW.flags : '0;

endmodule

`default_nettype wire

// File: verilog/fpuExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuExecute import fpuPkg::*; (
  input  fpuCtrl_t             ctrlE,
  input  logic [`FPU_FLEN-1:0] opA,
  input  logic [`FPU_FLEN-1:0] opB,
  input  logic [`FPU_XLEN-1:0] srcAE,
  output fpuExStage_t          stageE
);

  logic                 signRes;
  logic [`FPU_FLEN-1:0] sgnResult;
  logic                 lessEqual;
  fpuFlags_t            cmpFlags;
  logic [9:0]           classMask;
  fpuResSel_t           resSel;

  fpuCompare compare (
    .opA      (opA),
    .opB      (opB),
    .op       (ctrlE.op),
    .lessEqual(lessEqual),
    .flags    (cmpFlags)
  );

  fpuClassify classify (
    .op  (opA),
    .mask(classMask)
  );

  // sign injection, magnitude from opA
  always_comb begin
    case (ctrlE.op)
      opSgnjn: signRes = ~opB[`FPU_FLEN-1];
      opSgnjx: signRes = opA[`FPU_FLEN-1] ^ opB[`FPU_FLEN-1];
      default: signRes = opB[`FPU_FLEN-1];
    endcase
  end
  assign sgnResult = {signRes, opA[`FPU_FLEN-2:0]};

  // source of the result
  always_comb begin
    case (ctrlE.op)
      opFeq, opFlt, opFle: resSel = selCmp;
      opFclass:            resSel = selClass;
      opMvxd, opMvdx:      resSel = selMove;
      default:             resSel = selSign;
    endcase
  end

  always_comb begin
    stageE.ctrl  = ctrlE;
    // compare unit reports zero flags for other ops
    stageE.flags = cmpFlags;
    case (resSel)
      selCmp:   stageE.result = {{(`FPU_FLEN-1){1'b0}}, lessEqual};
      selClass: stageE.result = {{(`FPU_FLEN-10){1'b0}}, classMask};
      // fmv.d.x takes the integer operand as is
      selMove:  stageE.result = (ctrlE.op == opMvdx) ? srcAE : opA;
      default:  stageE.result = sgnResult;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/fpuClassify.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuClassify (
  input  logic [`FPU_FLEN-1:0] op,
  output logic [9:0]           mask
);

  localparam int Msb      = `FPU_FLEN - 1;
  localparam int FracBits = 52;

  logic sign;
  logic expOnes;
  logic expZero;
  logic fracZero;
  logic isInf;
  logic isNan;
  logic isZero;
  logic isSub;
  logic isNorm;

  assign sign     = op[Msb];
  assign expOnes  = (op[Msb-1:FracBits] == '1);
  assign expZero  = (op[Msb-1:FracBits] == '0);
  assign fracZero = (op[FracBits-1:0] == '0);

  // exactly one class holds
  assign isInf  = expOnes & fracZero;
  assign isNan  = expOnes & ~fracZero;
  assign isZero = expZero & fracZero;
  assign isSub  = expZero & ~fracZero;
  assign isNorm = ~expOnes & ~expZero;

  // negative classes
  assign mask[0] = sign & isInf;
  assign mask[1] = sign & isNorm;
  assign mask[2] = sign & isSub;
  assign mask[3] = sign & isZero;
  // positive classes
  assign mask[4] = ~sign & isZero;
  assign mask[5] = ~sign & isSub;
  assign mask[6] = ~sign & isNorm;
  assign mask[7] = ~sign & isInf;
  // nans ignore the sign, split on quiet bit
  assign mask[8] = isNan & ~op[FracBits-1];
  assign mask[9] = isNan & op[FracBits-1];

endmodule

`default_nettype wire

// File: verilog/fpuCompare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuCompare import fpuPkg::*; (
  input  logic [`FPU_FLEN-1:0] opA,
  input  logic [`FPU_FLEN-1:0] opB,
  input  fpuOp_t               op,
  output logic                 lessEqual,
  output fpuFlags_t            flags
);

  localparam int Msb      = `FPU_FLEN - 1;
  localparam int FracBits = 52;

  logic           signA;
  logic           signB;
  logic [Msb-1:0] magA;
  logic [Msb-1:0] magB;
  logic           nanA;
  logic           nanB;
  logic           snanA;
  logic           snanB;
  logic           bothZero;
  logic           eq;
  logic           lt;

  assign signA = opA[Msb];
  assign signB = opB[Msb];
  assign magA  = opA[Msb-1:0];
  assign magB  = opB[Msb-1:0];

  // exponent all ones, fraction nonzero
  assign nanA  = (opA[Msb-1:FracBits] == '1) && (opA[FracBits-1:0] != '0);
  assign nanB  = (opB[Msb-1:FracBits] == '1) && (opB[FracBits-1:0] != '0);
  // quiet bit clear
  assign snanA = nanA & ~opA[FracBits-1];
  assign snanB = nanB & ~opB[FracBits-1];

  // +0 and -0 compare equal
  assign bothZero = (magA == '0) && (magB == '0);
  assign eq       = (opA == opB) || bothZero;

  // sign-magnitude order
  always_comb begin
    if (signA != signB) begin
      lt = signA & ~bothZero;
    end else if (signA) begin
      lt = magA > magB;
    end else begin
      lt = magA < magB;
    end
  end

  always_comb begin
    lessEqual = 1'b0;
    flags     = '0;
    case (op)
      opFeq: begin
        lessEqual = eq;
        // feq is a quiet compare
        flags.nv  = snanA | snanB;
      end
      opFlt: begin
        lessEqual = lt;
        flags.nv  = nanA | nanB;
      end
      opFle: begin
        lessEqual = lt | eq;
        flags.nv  = nanA | nanB;
      end
      default: lessEqual = 1'b0;
    endcase
    // unordered
    if (nanA | nanB) begin
      lessEqual = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpuForward.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuForward import fpuPkg::*; (
  input  fpuCtrl_t             ctrlE,
  input  logic [`FPU_FLEN-1:0] rdata1E,
  input  logic [`FPU_FLEN-1:0] rdata2E,
  input  fpuExStage_t          stageM,
  input  fpuExStage_t          stageW,
  output logic [`FPU_FLEN-1:0] opA,
  output logic [`FPU_FLEN-1:0] opB
);

  // does a stage produce an fp value for register rs
  function automatic logic hits(input fpuExStage_t stage, input logic [4:0] rs);
    return stage.ctrl.valid && stage.ctrl.writeFp && (stage.ctrl.rd == rs);
  endfunction

  // youngest older producer wins
  function automatic logic [`FPU_FLEN-1:0] pick(
    input logic [4:0]           rs,
    input logic [`FPU_FLEN-1:0] rdata,
    input fpuExStage_t          m,
    input fpuExStage_t          w
  );
    logic [`FPU_FLEN-1:0] value;
    value = rdata;
    if (hits(w, rs)) begin
      value = w.result;
    end
    // M overrides W
    if (hits(m, rs)) begin
      value = m.result;
    end
    return value;
  endfunction

  assign opA = pick(ctrlE.rs1, rdata1E, stageM, stageW);
  assign opB = pick(ctrlE.rs2, rdata2E, stageM, stageW);

endmodule

`default_nettype wire

// File: verilog/fpuRegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuRegFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [4:0]           rs1,
  input  logic [4:0]           rs2,
  output logic [`FPU_FLEN-1:0] rdata1,
  output logic [`FPU_FLEN-1:0] rdata2,
  input  logic                 we,
  input  logic [4:0]           waddr,
  input  logic [`FPU_FLEN-1:0] wdata
);

  logic [`FPU_FLEN-1:0] regs [`FPU_NREGS];

  // no hardwired zero register on the fp side
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `FPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // write-through for a same-cycle W write
  assign rdata1 = (we && (waddr == rs1)) ? wdata : regs[rs1];
  assign rdata2 = (we && (waddr == rs2)) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/fpuDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpuDecode import fpuPkg::*; (
  input  logic [31:0] instr,
  input  logic        instrValid,
  output fpuCtrl_t    ctrl,
  output logic        illegalInstr
);

  // instruction fields
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2;

  // decoded controls
  logic       legal;
  fpuOp_t     op;
  logic       writeFp;
  logic       writeInt;

  assign opcode = instr[6:0];
  assign funct7 = instr[31:25];
  assign funct3 = instr[14:12];
  assign rs2    = instr[24:20];

  always_comb begin
    legal    = 1'b0;
    op       = opSgnj;
    writeFp  = 1'b0;
    writeInt = 1'b0;
    if (opcode == `FPU_OPFP) begin
      case (funct7)
        // fsgnj / fsgnjn / fsgnjx
        `FPU_F7_SGNJ: begin
          writeFp = 1'b1;
          legal   = (funct3 <= 3'b010);
          case (funct3)
            3'b000:  op = opSgnj;
            3'b001:  op = opSgnjn;
            default: op = opSgnjx;
          endcase
        end
        // feq / flt / fle, result to integer side
        `FPU_F7_CMP: begin
          writeInt = 1'b1;
          legal    = (funct3 <= 3'b010);
          case (funct3)
            3'b010:  op = opFeq;
            3'b001:  op = opFlt;
            default: op = opFle;
          endcase
        end
        // fclass / fmv.x.d, rs2 must be zero
        `FPU_F7_CLASSMVX: begin
          writeInt = 1'b1;
          legal    = (rs2 == 5'd0) && (funct3 <= 3'b001);
          op       = funct3[0] ? opFclass : opMvxd;
        end
        // fmv.d.x
        `FPU_F7_MVDX: begin
          writeFp = 1'b1;
          legal   = (rs2 == 5'd0) && (funct3 == 3'b000);
          op      = opMvdx;
        end
        default: legal = 1'b0;
      endcase
    end
  end

  // illegal ops go down the pipe as bubbles
  always_comb begin
    ctrl.valid    = instrValid & legal;
    ctrl.writeFp  = writeFp;
    ctrl.writeInt = writeInt;
    ctrl.op       = op;
    ctrl.rd       = instr[11:7];
    ctrl.rs1      = instr[19:15];
    ctrl.rs2      = rs2;
  end

  assign illegalInstr = instrValid & ~legal;

endmodule

`default_nettype wire

// File: verilog/fpuPkg.sv
`default_nettype none

`include "fpu_defines.svh"

package fpuPkg;

  // ****************************************
  // operations and result sources
  // ****************************************

  // kept double-precision ops
  typedef enum logic [3:0] {
    opSgnj,
    opSgnjn,
    opSgnjx,
    opFeq,
    opFlt,
    opFle,
    opFclass,
    opMvxd,
    opMvdx
  } fpuOp_t;

  // which unit feeds the stage result
  typedef enum logic [1:0] {
    selSign,
    selCmp,
    selClass,
    selMove
  } fpuResSel_t;

  // fflags layout, nv is the msb
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fpuFlags_t;

  // ****************************************
  // pipeline payloads
  // ****************************************

  // control travelling D through W
  typedef struct packed {
    logic       valid;
    logic       writeFp;
    logic       writeInt;
    fpuOp_t     op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } fpuCtrl_t;

  // E/M and M/W contents
  typedef struct packed {
    fpuCtrl_t             ctrl;
    logic [`FPU_FLEN-1:0] result;
    fpuFlags_t            flags;
  } fpuExStage_t;

endpackage

`default_nettype wire

// File: verilog/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// datapath widths
`define FPU_XLEN 64
`define FPU_FLEN 64

// fp register count
`define FPU_NREGS 32

// OP-FP major opcode
`define FPU_OPFP 7'b1010011

// funct7 group codes, fmt field = 01 (double)
`define FPU_F7_SGNJ     7'b0010001
`define FPU_F7_CMP      7'b1010001
// fclass and fmv.x.d share this code, split by funct3
`define FPU_F7_CLASSMVX 7'b1110001
`define FPU_F7_MVDX     7'b1111001

`endif
